// ==== hdl/vec_pkg.sv ====
package vec_pkg;

    localparam int elem_width = 10;                 // one vector element, 10 bit unsigned
    localparam int word_width = 32;                 // one result word on the output side

    // one result word, seen as a number or as the bytes it leaves in
    typedef union packed {
        logic [word_width-1:0] word;                // arithmetic view, core and result store
        logic [3:0][7:0]       lanes;               // byte view, lanes[0] goes out first
    } result_word_t;

endpackage

// ==== hdl/cmd_pkg.sv ====
package cmd_pkg;

    localparam int opcode_bits = 4;                 // low nibble of the command byte

    typedef enum logic [opcode_bits-1:0] {
        write_a = 4'h0,                             // load vector a
        write_b = 4'h1,                             // load vector b
        op_sum  = 4'h2,                             // a + b per element
        op_avg  = 4'h3,                             // (a + b) / 2 per element
        op_man  = 4'h4,                             // sum |a - b|
        op_euc  = 4'h5,                             // sum (a - b)^2
        op_dot  = 4'h6                              // sum a * b
    } opcode_t;

    // opcode field of a received command byte, upper nibble ignored
    function automatic opcode_t byte_opcode(input logic [7:0] cmd_byte);
        return opcode_t'(cmd_byte[opcode_bits-1:0]);
    endfunction

    function automatic logic is_known_op(input opcode_t op);
        return op inside {write_a, write_b, op_sum, op_avg, op_man, op_euc, op_dot};
    endfunction

    function automatic logic is_write_op(input opcode_t op);
        return (op == write_a) || (op == write_b);
    endfunction

    // element-wise ops return one word per element, the rest a single word
    function automatic logic is_vector_op(input opcode_t op);
        return (op == op_sum) || (op == op_avg);
    endfunction

endpackage

// ==== hdl/coproc_ifs.sv ====
`timescale 1ns/1ps

interface operand_if #(parameter int num_elements = 8);
    import vec_pkg::*;
    import cmd_pkg::*;

    logic [num_elements-1:0][elem_width-1:0] data_a;    // stored vector a
    logic [num_elements-1:0][elem_width-1:0] data_b;    // stored vector b
    opcode_t                                 op;        // operation for the next start
    logic                                    start;     // one cycle launch pulse

    modport src  (output data_a, data_b);
    modport ctrl (output op, start);
    modport core (input data_a, data_b, op, start);
endinterface

interface result_if #(parameter int num_elements = 8);
    import vec_pkg::*;
    import cmd_pkg::*;

    result_word_t [num_elements-1:0] par_result;       // per element results
    result_word_t                    scalar_result;    // reduced result
    opcode_t                         op;               // op that produced them
    logic                            valid;            // results ready this cycle

    modport core (output par_result, scalar_result, op, valid);
    modport mem  (input par_result, scalar_result, op, valid);
endinterface

// ==== hdl/sipo_input_interface.sv ====
`timescale 1ns/1ps

module sipo_input_interface #(
    parameter int num_elements = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [7:0]       rx_data,
    input  logic             rx_valid,
    input  logic             busy,
    operand_if.src           opif,
    output logic             command_ready,
    output cmd_pkg::opcode_t command
);
    import vec_pkg::*;
    import cmd_pkg::*;

    localparam int cnt_w   = (num_elements > 1) ? $clog2(num_elements) : 1;
    localparam int hi_bits = elem_width - 8;        // bits taken from the high byte

    localparam logic [1:0] st_idle = 2'd0;          // waiting for a command byte
    localparam logic [1:0] st_low  = 2'd1;          // waiting for element low byte
    localparam logic [1:0] st_high = 2'd2;          // waiting for element high byte

    logic [1:0]            state;
    logic [cnt_w-1:0]      elem_cnt;                // elements received in this write
    logic                  wr_b;                    // current write targets vector b
    logic [7:0]            low_byte;                // held until the high byte arrives
    logic                  accept;
    logic                  op_cmd;                  // operation command taken this cycle
    opcode_t               rx_op;
    logic [elem_width-1:0] elem;                    // assembled element

    assign accept = rx_valid && !busy;              // bytes dropped while an op runs
    assign rx_op  = byte_opcode(rx_data);
    assign op_cmd = accept && (state == st_idle) && is_known_op(rx_op) && !is_write_op(rx_op);
    assign elem   = {rx_data[hi_bits-1:0], low_byte};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            elem_cnt      <= '0;
            wr_b          <= 1'b0;
            command_ready <= 1'b0;
        end else begin
            command_ready <= op_cmd;                // pulse the cycle after the byte
            if (accept) begin
                case (state)
                    st_idle: begin
                        if (is_write_op(rx_op)) begin
                            wr_b     <= (rx_op == write_b);
                            elem_cnt <= '0;
                            state    <= st_low;
                        end
                    end
                    st_low: state <= st_high;
                    st_high: begin
                        elem_cnt <= elem_cnt + 1'b1;
                        if (elem_cnt == cnt_w'(num_elements - 1)) begin
                            state <= st_idle;       // last element in
                        end else begin
                            state <= st_low;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // element 0 arrives first and ends up at index 0 after the last shift
    always_ff @(posedge clk) begin
        if (op_cmd) begin
            command <= rx_op;
        end
        if (accept && (state == st_low)) begin
            low_byte <= rx_data;
        end
        if (accept && (state == st_high)) begin
            if (wr_b) begin
                opif.data_b <= {elem, opif.data_b[num_elements-1:1]};
            end else begin
                opif.data_a <= {elem, opif.data_a[num_elements-1:1]};
            end
        end
    end

endmodule

// ==== hdl/processing_core.sv ====
`timescale 1ns/1ps

module processing_core #(
    parameter int num_elements = 8
) (
    input  logic    clk,
    input  logic    rst_n,
    operand_if.core opif,
    result_if.core  resif
);
    import vec_pkg::*;
    import cmd_pkg::*;

    logic [num_elements-1:0][elem_width-1:0]   abs_diff;   // |a - b|, combinational
    logic [num_elements-1:0][elem_width:0]     sum_s1;     // a + b with carry
    logic [num_elements-1:0][elem_width-1:0]   adiff_s1;
    logic [num_elements-1:0][2*elem_width-1:0] sq_s1;      // (a - b)^2
    logic [num_elements-1:0][2*elem_width-1:0] prod_s1;    // a * b
    logic [num_elements-1:0][elem_width:0]     sum_s2;
    logic [word_width-1:0]                     man_red;
    logic [word_width-1:0]                     euc_red;
    logic [word_width-1:0]                     dot_red;
    logic [word_width-1:0]                     man_s2;
    logic [word_width-1:0]                     euc_s2;
    logic [word_width-1:0]                     dot_s2;
    opcode_t                                   op_s1;
    opcode_t                                   op_s2;
    logic                                      v_s1;
    logic                                      v_s2;

    always_comb begin
        for (int i = 0; i < num_elements; i++) begin
            if (opif.data_a[i] > opif.data_b[i]) begin
                abs_diff[i] = opif.data_a[i] - opif.data_b[i];
            end else begin
                abs_diff[i] = opif.data_b[i] - opif.data_a[i];
            end
        end
    end

    // stage 1, per element terms
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_elements; i++) begin
            sum_s1[i]   <= opif.data_a[i] + opif.data_b[i];
            adiff_s1[i] <= abs_diff[i];
            sq_s1[i]    <= abs_diff[i] * abs_diff[i];
            prod_s1[i]  <= opif.data_a[i] * opif.data_b[i];
        end
        op_s1 <= opif.op;                           // op rides along with its data
    end

    // adder reduction over the stage 1 terms
    always_comb begin
        man_red = '0;
        euc_red = '0;
        dot_red = '0;
        for (int i = 0; i < num_elements; i++) begin
            man_red = man_red + word_width'(adiff_s1[i]);
            euc_red = euc_red + word_width'(sq_s1[i]);
            dot_red = dot_red + word_width'(prod_s1[i]);
        end
    end

    // stage 2, reduced sums and pass-through of the element sums
    always_ff @(posedge clk) begin
        sum_s2 <= sum_s1;
        man_s2 <= man_red;
        euc_s2 <= euc_red;
        dot_s2 <= dot_red;
        op_s2  <= op_s1;
    end

    // stage 3, result select
    always_ff @(posedge clk) begin
        if (v_s2) begin
            resif.op <= op_s2;
            if (is_vector_op(op_s2)) begin
                for (int i = 0; i < num_elements; i++) begin
                    if (op_s2 == op_avg) begin
                        resif.par_result[i].word <= word_width'(sum_s2[i] >> 1); // floor
                    end else begin
                        resif.par_result[i].word <= word_width'(sum_s2[i]);
                    end
                end
            end else begin
                case (op_s2)
                    op_man:  resif.scalar_result.word <= man_s2;
                    op_euc:  resif.scalar_result.word <= euc_s2;
                    default: resif.scalar_result.word <= dot_s2;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_s1        <= 1'b0;
            v_s2        <= 1'b0;
            resif.valid <= 1'b0;
        end else begin
            v_s1        <= opif.start;
            v_s2        <= v_s1;
            resif.valid <= v_s2;                    // 3 cycles after start
        end
    end

endmodule

// ==== hdl/pipeline_ctrl_unit.sv ====
`timescale 1ns/1ps

module pipeline_ctrl_unit #(
    parameter int num_elements = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             command_ready,
    input  cmd_pkg::opcode_t command,
    input  logic             word_sent,
    operand_if.ctrl          opif,
    output logic             busy,
    output logic             shift_mem
);
    import cmd_pkg::*;

    localparam int cnt_w = $clog2(num_elements + 1);

    logic             busy_q;                       // op in flight until last word out
    logic [cnt_w-1:0] words_left;                   // result words still to be sent

    assign busy      = busy_q || command_ready;     // high already in the command cycle
    assign shift_mem = word_sent && busy_q;         // advance store on each sent word

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            words_left <= '0;
            opif.start <= 1'b0;
        end else begin
            opif.start <= command_ready;            // launch one cycle later
            if (command_ready) begin
                busy_q <= 1'b1;
                if (is_vector_op(command)) begin
                    words_left <= cnt_w'(num_elements);
                end else begin
                    words_left <= cnt_w'(1);
                end
            end else if (shift_mem) begin
                words_left <= words_left - 1'b1;
                if (words_left == cnt_w'(1)) begin
                    busy_q <= 1'b0;                 // last word gone
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (command_ready) begin
            opif.op <= command;                     // valid together with start
        end
    end

endmodule

// ==== hdl/result_mem.sv ====
`timescale 1ns/1ps

module result_mem #(
    parameter int num_elements = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    result_if.mem                resif,
    input  logic                 shift_mem,
    output vec_pkg::result_word_t result_out,
    output logic                 out_valid
);
    import vec_pkg::*;
    import cmd_pkg::*;

    localparam int cnt_w = $clog2(num_elements + 1);

    result_word_t     mem [num_elements];           // head at index 0
    logic [cnt_w-1:0] count;                        // words left in the store

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (resif.valid) begin
            if (is_vector_op(resif.op)) begin
                count <= cnt_w'(num_elements);
            end else begin
                count <= cnt_w'(1);
            end
        end else if (shift_mem && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resif.valid) begin
            if (is_vector_op(resif.op)) begin
                for (int i = 0; i < num_elements; i++) begin
                    mem[i].word <= resif.par_result[i].word;   // parallel load
                end
            end else begin
                mem[0].word <= resif.scalar_result.word;
            end
        end else if (shift_mem) begin
            for (int i = 0; i < num_elements - 1; i++) begin
                mem[i] <= mem[i+1];                 // move toward the head
            end
        end
    end

    assign result_out = mem[0];
    assign out_valid  = (count != '0);

endmodule

// ==== hdl/output_interface.sv ====
`timescale 1ns/1ps

module output_interface (
    input  logic                  clk,
    input  logic                  rst_n,
    input  vec_pkg::result_word_t result_out,
    input  logic                  out_valid,
    output logic [7:0]            tx_data,
    output logic                  tx_valid,
    input  logic                  tx_ready,
    output logic                  word_sent
);
    import vec_pkg::*;

    result_word_t word_q;                           // word being sent
    logic [1:0]   lane;                             // current byte lane
    logic         xfer;                             // byte handshake this cycle

    assign xfer      = tx_valid && tx_ready;
    assign word_sent = xfer && (lane == 2'd3);      // fourth byte of the word
    assign tx_data   = word_q.lanes[lane];          // little endian, held while stalled

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
            lane     <= 2'd0;
        end else if (!tx_valid) begin
            if (out_valid) begin
                tx_valid <= 1'b1;                   // one cycle after word shows up
                lane     <= 2'd0;
            end
        end else if (xfer) begin
            lane <= lane + 2'd1;                    // wraps to 0 after lane 3
            if (lane == 2'd3) begin
                tx_valid <= 1'b0;                   // let the store advance
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!tx_valid && out_valid) begin
            word_q <= result_out;
        end
    end

endmodule

// ==== hdl/vec_coproc_top.sv ====
`timescale 1ns/1ps

module vec_coproc_top #(
    parameter int num_elements = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] rx_data,                     // received byte
    input  logic       rx_valid,                    // byte present this cycle
    output logic [7:0] tx_data,                     // byte to send
    output logic       tx_valid,
    input  logic       tx_ready,                    // sink takes the byte
    output logic       busy                         // op running, input ignored
);
    import vec_pkg::*;
    import cmd_pkg::*;

    operand_if #(.num_elements(num_elements)) opif ();
    result_if  #(.num_elements(num_elements)) resif ();

    logic         command_ready;
    opcode_t      command;
    logic         word_sent;
    logic         shift_mem;
    logic         out_valid;
    result_word_t result_out;

    sipo_input_interface #(.num_elements(num_elements)) i_sipo_input_interface (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .busy          (busy),
        .opif          (opif.src),
        .command_ready (command_ready),
        .command       (command)
    );

    processing_core #(.num_elements(num_elements)) i_processing_core (
        .clk   (clk),
        .rst_n (rst_n),
        .opif  (opif.core),
        .resif (resif.core)
    );

    pipeline_ctrl_unit #(.num_elements(num_elements)) i_pipeline_ctrl_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .command_ready (command_ready),
        .command       (command),
        .word_sent     (word_sent),
        .opif          (opif.ctrl),
        .busy          (busy),
        .shift_mem     (shift_mem)
    );

    result_mem #(.num_elements(num_elements)) i_result_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .resif      (resif.mem),
        .shift_mem  (shift_mem),
        .result_out (result_out),
        .out_valid  (out_valid)
    );

    output_interface i_output_interface (
        .clk        (clk),
        .rst_n      (rst_n),
        .result_out (result_out),
        .out_valid  (out_valid),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .word_sent  (word_sent)
    );

endmodule

// ==== verification/vec_coproc_assertions.sv ====
`timescale 1ns/1ps

module vec_coproc_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic [7:0] tx_data,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic       word_sent
);
    int         fail_count = 0;                     // assertion failures so far
    logic [1:0] xfer_cnt;                           // bytes moved within the current word

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xfer_cnt <= 2'd0;
        end else if (tx_valid && tx_ready) begin
            xfer_cnt <= xfer_cnt + 2'd1;            // wraps after the fourth byte
        end
    end

    property hold_under_stall;                      // byte and valid held while sink stalls
        @(posedge clk) disable iff (!rst_n)
            (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data));
    endproperty

    property quiet_after_reset;                     // nothing offered coming out of reset
        @(posedge clk) !rst_n |=> !tx_valid;
    endproperty

    property word_sent_on_fourth;                   // word_sent exactly on every fourth byte
        @(posedge clk) disable iff (!rst_n)
            word_sent == (tx_valid && tx_ready && (xfer_cnt == 2'd3));
    endproperty

    a_hold: assert property (hold_under_stall) else begin
        $error("tx_data or tx_valid changed while tx_ready was low");
        fail_count++;
    end

    a_reset: assert property (quiet_after_reset) else begin
        $error("tx_valid high in the cycle after reset");
        fail_count++;
    end

    a_sent: assert property (word_sent_on_fourth) else begin
        $error("word_sent did not match the fourth byte transfer of a word");
        fail_count++;
    end

endmodule

// ==== verification/vec_coproc_tb.sv ====
`timescale 1ns/1ps

module vec_coproc_tb;
    import cmd_pkg::*;

    localparam int num_elements = 8;
    localparam int rec_words    = 3 + 3 * num_elements;   // op, load, count, a, b, expected

    logic        clk;
    logic        rst_n;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        tx_ready;
    logic        busy;

    logic [31:0] tdata [0:255];                     // record image from the data file
    logic [31:0] exp_words [num_elements];          // expected words of the running op
    logic [31:0] rnd;                               // xorshift state
    logic [31:0] rx_word;                           // word assembled from tx bytes
    int          exp_count;                         // 0 when no result is awaited
    int          got_words;
    int          got_bytes;
    int          num_records;
    int          errors;
    int          passed;
    int          failed;

    vec_coproc_top #(.num_elements(num_elements)) i_vec_coproc_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .busy     (busy)
    );

    bind output_interface vec_coproc_assertions i_vec_coproc_assertions (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .word_sent (word_sent)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;                          // 10 ns period
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic take_byte(input logic [7:0] b);
        assert (got_words < exp_count) else begin
            $display("unexpected tx byte 0x%02h at %0t ns with no result word pending", b, $time);
            errors++;
        end
        rx_word[8 * (got_bytes % 4) +: 8] = b;      // first byte is bits 7:0
        got_bytes++;
        if (got_bytes % 4 == 0) begin
            if (got_words < exp_count) begin
                assert (rx_word == exp_words[got_words]) else begin
                    $display("MISMATCH at %0t ns: tx_word[%0d] expected 0x%08h actual 0x%08h",
                             $time, got_words, exp_words[got_words], rx_word);
                    errors++;
                end
            end
            got_words++;
        end
    endtask

    // new tx_ready each clock and note the byte that moves at the next rising edge
    task automatic cycle_tx();
        @(negedge clk);
        rnd      = xorshift(rnd);
        tx_ready = (rnd[1:0] != 2'b00);             // about one stall in four
        if (tx_valid && tx_ready) begin
            take_byte(tx_data);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        rx_data  = b;
        rx_valid = 1'b1;
        cycle_tx();                                 // taken at the edge in between
        rx_valid = 1'b0;
    endtask

    task automatic write_vector(input opcode_t wr, input int first);
        rnd = xorshift(rnd);
        send_byte({rnd[7:4], wr});                  // upper nibble is noise
        for (int i = 0; i < num_elements; i++) begin
            send_byte(tdata[first + i][7:0]);
            send_byte({rnd[15:10], tdata[first + i][9:8]});   // only bits 1:0 count
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            passed++;
            $display("test %s ok", name);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic check_reset_idle();
        int errors_before;
        errors_before = errors;
        assert (!tx_valid && !busy) else begin
            $display("tx_valid or busy high right after reset at %0t ns", $time);
            errors++;
        end
        exp_count = 0;                              // any byte now is a stray
        repeat (20) cycle_tx();
        report_test("reset_idle", errors_before);
    endtask

    task automatic run_record(input int r);
        int      base;
        int      errors_before;
        opcode_t opc;
        base          = 1 + r * rec_words;
        errors_before = errors;
        opc           = opcode_t'(tdata[base][3:0]);
        if (tdata[base + 1][0]) begin
            write_vector(write_a, base + 3);
            write_vector(write_b, base + 3 + num_elements);
        end
        exp_count = int'(tdata[base + 2]);
        for (int i = 0; i < num_elements; i++) begin
            exp_words[i] = tdata[base + 3 + 2 * num_elements + i];
        end
        got_words = 0;
        got_bytes = 0;
        rnd = xorshift(rnd);
        send_byte({rnd[7:4], opc});
        assert (busy) else begin
            $display("busy did not rise after the %s command at %0t ns", opc.name(), $time);
            errors++;
        end
        while (busy) begin
            rnd      = xorshift(rnd);
            rx_data  = rnd[15:8];                   // junk that must be dropped
            rx_valid = rnd[16];
            cycle_tx();
        end
        rx_valid = 1'b0;
        assert (got_bytes == 4 * exp_count) else begin
            $display("busy fell after %0d of %0d result bytes at %0t ns",
                     got_bytes, 4 * exp_count, $time);
            errors++;
        end
        exp_count = 0;
        got_words = 0;
        got_bytes = 0;
        report_test($sformatf("%0d_%s", r + 1, opc.name()), errors_before);
    endtask

    initial begin
        rst_n     = 1'b0;
        rx_data   = 8'h00;
        rx_valid  = 1'b0;
        tx_ready  = 1'b0;
        rnd       = 32'd24;
        rx_word   = '0;
        exp_count = 0;
        got_words = 0;
        got_bytes = 0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        $readmemh("verification/vec_coproc_testdata.mem", tdata);
        num_records = int'(tdata[0]);
        assert (num_records > 0) else begin
            $display("no test records read from the data file");
            errors++;
        end
        repeat (3) cycle_tx();                      // reset over three rising edges
        rst_n = 1'b1;
        check_reset_idle();
        for (int r = 0; r < num_records; r++) begin
            run_record(r);
        end
        errors = errors + i_vec_coproc_top.i_output_interface.i_vec_coproc_assertions.fail_count;
        $display("%0d tests, %0d passed, %0d failed, %0d errors in total",
                 passed + failed, passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        #1;
        limit = num_records * 36 * 20 + 100;        // bytes per record times cycles per byte
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== verification/vec_coproc_testdata.mem ====
// record count, then per record: opcode load word_count / a[0..7] / b[0..7] / expected words
// load 1 writes a and b before the op, load 0 reuses the stored vectors
7
2 1 8
003 064 3ff 200 000 007 0fa 320
005 0c8 3ff 1ff 009 000 0fa 064
00000008 0000012c 000007fe 000003ff 00000009 00000007 000001f4 00000384
3 0 8
003 064 3ff 200 000 007 0fa 320
005 0c8 3ff 1ff 009 000 0fa 064
00000004 00000096 000003ff 000001ff 00000004 00000003 000000fa 000001c2
4 1 1
00a 014 01e 028 032 03c 046 050
00f 005 01e 064 000 3ff 045 05a
00000450 00000000 00000000 00000000 00000000 00000000 00000000 00000000
5 0 1
00a 014 01e 028 032 03c 046 050
00f 005 01e 064 000 3ff 045 05a
000e3fbc 00000000 00000000 00000000 00000000 00000000 00000000 00000000
6 1 1
3ff 3ff 3e8 002 200 12c 000 001
3ff 001 3e8 003 200 190 309 001
00251307 00000000 00000000 00000000 00000000 00000000 00000000 00000000
6 0 1
3ff 3ff 3e8 002 200 12c 000 001
3ff 001 3e8 003 200 190 309 001
00251307 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2 0 8
3ff 3ff 3e8 002 200 12c 000 001
3ff 001 3e8 003 200 190 309 001
000007fe 00000400 000007d0 00000005 00000400 000002bc 00000309 00000002

// ==== vec_coproc.f ====
hdl/vec_pkg.sv
hdl/cmd_pkg.sv
hdl/coproc_ifs.sv
hdl/sipo_input_interface.sv
hdl/processing_core.sv
hdl/pipeline_ctrl_unit.sv
hdl/result_mem.sv
hdl/output_interface.sv
hdl/vec_coproc_top.sv
verification/vec_coproc_assertions.sv
verification/vec_coproc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module vec_coproc_tb \
    -f vec_coproc.f -o vec_coproc_sim > build.log 2>&1 \
    && ./obj_dir/vec_coproc_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "^TESTBENCH PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
